/* design/rvDecodePkg.sv */
package rvDecodePkg;

    // alu operation select
    typedef enum logic [3:0]
    {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASSB = 4'd10 // lui passes the immediate
    } aluFnT;

    // operand b source
    typedef enum logic [1:0]
    {
        B_REG     = 2'd0,
        B_IMM     = 2'd1,
        B_PCPLUS4 = 2'd2 // reserved
    } bSelT;

    // write-back source
    typedef enum logic [1:0]
    {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wbSelT;

    typedef enum logic [3:0]
    {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LBU  = 4'd4,
        MEM_LHU  = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } memOpT;

    // next pc source
    typedef enum logic [1:0]
    {
        PC_SEQ    = 2'd0,
        PC_BRANCH = 2'd1,
        PC_JAL    = 2'd2,
        PC_JALR   = 2'd3
    } pcSelT;

    typedef enum logic [2:0]
    {
        FMT_NONE = 3'd0,
        FMT_I    = 3'd1,
        FMT_S    = 3'd2,
        FMT_B    = 3'd3,
        FMT_U    = 3'd4,
        FMT_J    = 3'd5
    } immFmtT;

    // rv32i major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // registered decode result
    typedef struct packed
    {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic        regWe;
        aluFnT       aluFn;
        bSelT        bSel;
        wbSelT       wbSel;
        memOpT       memOp;
        pcSelT       pcSel;
        logic [31:0] imm;
        logic [31:0] target; // pc + imm
        logic [31:0] pc;
        logic        illegal;
    } decodedT;

endpackage

/* design/immIf.sv */
`timescale 1ns/1ps

// the five extracted immediates, all already sign-extended
interface immIf;

    logic [31:0] iImm;
    logic [31:0] sImm;
    logic [31:0] bImm;
    logic [31:0] uImm;
    logic [31:0] jImm;

    modport src
    (
        output iImm, sImm, bImm, uImm, jImm
    );

    modport dst
    (
        input iImm, sImm, bImm, uImm, jImm
    );

endinterface

/* design/ctrlIf.sv */
`timescale 1ns/1ps

// decoded control fields, decoder to merge
interface ctrlIf;

    import rvDecodePkg::*;

    logic   regWe;
    aluFnT  aluFn;
    bSelT   bSel;
    wbSelT  wbSel;
    memOpT  memOp;
    pcSelT  pcSel;
    immFmtT immFmt;  // which immediate the merge picks
    logic   illegal;

    modport src
    (
        output regWe, aluFn, bSel, wbSel, memOp, pcSel, immFmt, illegal
    );

    modport dst
    (
        input regWe, aluFn, bSel, wbSel, memOp, pcSel, immFmt, illegal
    );

endinterface

/* design/immGen.sv */
`timescale 1ns/1ps

module immGen
(
    input  logic [31:0] instr,
    immIf.src           imm
);

    logic        sign;      // instruction bit 31
    logic [11:0] iField;
    logic [11:0] sField;
    logic [12:0] bField;    // bit 0 always zero
    logic [19:0] uField;
    logic [20:0] jField;    // bit 0 always zero

    assign sign = instr[31];

    // raw fields as laid out in the spec
    assign iField = instr[31:20];
    assign sField = {instr[31:25], instr[11:7]};
    assign bField = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign uField = instr[31:12];
    assign jField = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // sign extension from bit 31
    assign imm.iImm = {{20{sign}}, iField};
    assign imm.sImm = {{20{sign}}, sField};
    assign imm.bImm = {{19{sign}}, bField};
    assign imm.uImm = {uField, 12'b0}; // low bits zero
    assign imm.jImm = {{11{sign}}, jField};

endmodule

/* design/controlDecoder.sv */
`timescale 1ns/1ps

module controlDecoder
(
    input  logic [31:0] instr,
    ctrlIf.src          ctrl
);

    import rvDecodePkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       bit30;      // sub/sra select

    logic   regWe;
    aluFnT  aluFn;
    bSelT   bSel;
    wbSelT  wbSel;
    memOpT  memOp;
    pcSelT  pcSel;
    immFmtT immFmt;
    logic   illegal;

    // shared by op and op-imm, alt picks sub or sra
    function automatic aluFnT aluFromFunct3(input logic [2:0] f3, input logic alt);
        aluFnT fn;
        case (f3)
            3'b000:  fn = alt ? ALU_SUB : ALU_ADD;
            3'b001:  fn = ALU_SLL;
            3'b010:  fn = ALU_SLT;
            3'b011:  fn = ALU_SLTU;
            3'b100:  fn = ALU_XOR;
            3'b101:  fn = alt ? ALU_SRA : ALU_SRL;
            3'b110:  fn = ALU_OR;
            default: fn = ALU_AND;
        endcase
        return fn;
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign bit30  = instr[30];

    always_comb
    begin
        regWe   = 1'b0;
        aluFn   = ALU_ADD;
        bSel    = B_REG;
        wbSel   = WB_ALU;
        memOp   = MEM_NONE;
        pcSel   = PC_SEQ;
        immFmt  = FMT_NONE;
        illegal = 1'b0;
        case (opcode)
            OPC_OP:
            begin
                regWe = 1'b1;
                aluFn = aluFromFunct3(funct3, bit30);
            end
            OPC_OPIMM:
            begin
                regWe  = 1'b1;
                bSel   = B_IMM;
                immFmt = FMT_I;
                aluFn  = aluFromFunct3(funct3, bit30 && (funct3 == 3'b101)); // no subi
            end
            OPC_LUI:
            begin
                regWe  = 1'b1;
                bSel   = B_IMM;
                aluFn  = ALU_PASSB;
                immFmt = FMT_U;
            end
            OPC_AUIPC:
            begin
                regWe  = 1'b1;
                bSel   = B_IMM;
                immFmt = FMT_U;
            end
            OPC_LOAD:
            begin
                regWe  = 1'b1;
                bSel   = B_IMM;
                wbSel  = WB_MEM;
                immFmt = FMT_I;
                case (funct3)
                    3'b000:  memOp = MEM_LB;
                    3'b001:  memOp = MEM_LH;
                    3'b010:  memOp = MEM_LW;
                    3'b100:  memOp = MEM_LBU;
                    3'b101:  memOp = MEM_LHU;
                    default: illegal = 1'b1;
                endcase
            end
            OPC_STORE:
            begin
                bSel   = B_IMM;
                immFmt = FMT_S;
                case (funct3)
                    3'b000:  memOp = MEM_SB;
                    3'b001:  memOp = MEM_SH;
                    3'b010:  memOp = MEM_SW;
                    default: illegal = 1'b1;
                endcase
            end
            OPC_BRANCH:
            begin
                immFmt = FMT_B;
                pcSel  = PC_BRANCH;
                case (funct3)
                    3'b100, 3'b101: aluFn = ALU_SLT;   // blt, bge
                    3'b110, 3'b111: aluFn = ALU_SLTU;  // bltu, bgeu
                    default:        aluFn = ALU_SUB;
                endcase
            end
            OPC_JAL:
            begin
                regWe  = 1'b1;
                wbSel  = WB_PC4;
                immFmt = FMT_J;
                pcSel  = PC_JAL;
            end
            OPC_JALR:
            begin
                regWe  = 1'b1;
                bSel   = B_IMM;
                wbSel  = WB_PC4;
                immFmt = FMT_I;
                pcSel  = PC_JALR;
            end
            default: illegal = 1'b1; // fence, system and unknown
        endcase
        // illegal words must not write or touch memory
        if (illegal)
        begin
            regWe = 1'b0;
            memOp = MEM_NONE;
            pcSel = PC_SEQ;
        end
    end

    assign ctrl.regWe   = regWe;
    assign ctrl.aluFn   = aluFn;
    assign ctrl.bSel    = bSel;
    assign ctrl.wbSel   = wbSel;
    assign ctrl.memOp   = memOp;
    assign ctrl.pcSel   = pcSel;
    assign ctrl.immFmt  = immFmt;
    assign ctrl.illegal = illegal;

endmodule

/* design/decodeMerge.sv */
`timescale 1ns/1ps

module decodeMerge
(
    input  logic                clk,
    input  logic                nrst,
    input  logic                inValid,
    input  logic                stall,
    input  logic [31:0]         instr,
    input  logic [31:0]         pc,
    immIf.dst                   imm,
    ctrlIf.dst                  ctrl,
    output logic                outValid,
    output rvDecodePkg::decodedT dec
);

    import rvDecodePkg::*;

    logic [31:0] immSel;    // immediate for this format
    logic [31:0] target;
    decodedT     nextDec;

    always_comb
    begin
        case (ctrl.immFmt)
            FMT_I:   immSel = imm.iImm;
            FMT_S:   immSel = imm.sImm;
            FMT_B:   immSel = imm.bImm;
            FMT_U:   immSel = imm.uImm;
            FMT_J:   immSel = imm.jImm;
            default: immSel = 32'd0;   // r-type has none
        endcase
    end

    assign target = pc + immSel;   // wraps mod 2^32

    always_comb
    begin
        nextDec.rs1     = instr[19:15];
        nextDec.rs2     = instr[24:20];
        nextDec.rd      = instr[11:7];
        nextDec.regWe   = ctrl.regWe;
        nextDec.aluFn   = ctrl.aluFn;
        nextDec.bSel    = ctrl.bSel;
        nextDec.wbSel   = ctrl.wbSel;
        nextDec.memOp   = ctrl.memOp;
        nextDec.pcSel   = ctrl.pcSel;
        nextDec.imm     = immSel;
        nextDec.target  = target;
        nextDec.pc      = pc;
        nextDec.illegal = ctrl.illegal; // flagged, still passed on
    end

    // pipeline register, holds on stall
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            outValid    <= 1'b0;
            dec         <= '0;
            dec.aluFn   <= ALU_ADD;
            dec.bSel    <= B_REG;
            dec.wbSel   <= WB_ALU;
            dec.memOp   <= MEM_NONE;
            dec.pcSel   <= PC_SEQ;
        end
        else if (!stall)
        begin
            outValid <= inValid;
            dec      <= nextDec;   // bubble contents are don't-care
        end
    end

endmodule

/* design/rvDecode.sv */
`timescale 1ns/1ps

module rvDecode
(
    input  logic                clk,
    input  logic                nrst,
    input  logic                inValid,
    input  logic [31:0]         instr,
    input  logic [31:0]         pc,
    input  logic                stall,
    output logic                outValid,
    output logic [4:0]          rs1,
    output logic [4:0]          rs2,
    output logic [4:0]          rd,
    output logic                regWe,
    output rvDecodePkg::aluFnT  aluFn,
    output rvDecodePkg::bSelT   bSel,
    output rvDecodePkg::wbSelT  wbSel,
    output rvDecodePkg::memOpT  memOp,
    output rvDecodePkg::pcSelT  pcSel,
    output logic [31:0]         imm,
    output logic [31:0]         target,
    output logic [31:0]         pcOut,
    output logic                illegal
);

    import rvDecodePkg::*;

    decodedT dec;   // registered bundle

    immIf  immBus ();
    ctrlIf ctrlBus ();

    // both decoders see the raw word in parallel
    immGen immGen_i
    (
        .instr (instr),
        .imm   (immBus.src)
    );

    controlDecoder controlDecoder_i
    (
        .instr (instr),
        .ctrl  (ctrlBus.src)
    );

    decodeMerge decodeMerge_i
    (
        .clk      (clk),
        .nrst     (nrst),
        .inValid  (inValid),
        .stall    (stall),
        .instr    (instr),
        .pc       (pc),
        .imm      (immBus.dst),
        .ctrl     (ctrlBus.dst),
        .outValid (outValid),
        .dec      (dec)
    );

    assign rs1     = dec.rs1;
    assign rs2     = dec.rs2;
    assign rd      = dec.rd;
    assign regWe   = dec.regWe;
    assign aluFn   = dec.aluFn;
    assign bSel    = dec.bSel;
    assign wbSel   = dec.wbSel;
    assign memOp   = dec.memOp;
    assign pcSel   = dec.pcSel;
    assign imm     = dec.imm;
    assign target  = dec.target;
    assign pcOut   = dec.pc;
    assign illegal = dec.illegal;

endmodule

/* tb/decodeModel.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected decode of one word, care marks the fields the rules define
function automatic decodedT modelDecode(input logic [31:0] w, input logic [31:0] pc,
                                        output decodedT care);
    decodedT     d;
    logic [31:0] immI;
    logic [2:0]  f3;
    aluFnT       alu [0:7];
    immI = $signed(w) >>> 20;
    f3   = w[14:12];
    alu  = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
    d    = '0;              // reg, alu, none and seq all encode as zero
    care = '1;
    d.rs1   = w[19:15];
    d.rs2   = w[24:20];
    d.rd    = w[11:7];
    d.pc    = pc;
    d.regWe = 1'b1;         // cleared for store, branch, illegal
    case (w[6:0])
        OPC_OP:
        begin
            d.aluFn = alu[f3];
            if (w[30] && f3 == 3'b000)
                d.aluFn = ALU_SUB;
            if (w[30] && f3 == 3'b101)
                d.aluFn = ALU_SRA;
        end
        OPC_OPIMM:
        begin
            d.aluFn = (w[30] && f3 == 3'b101) ? ALU_SRA : alu[f3];
            d.bSel  = B_IMM;
            d.imm   = immI;
        end
        OPC_LUI:
        begin
            d.bSel  = B_IMM;
            d.aluFn = ALU_PASSB;
            d.imm   = {w[31:12], 12'h000};
        end
        OPC_AUIPC:
        begin
            d.imm     = {w[31:12], 12'h000};
            care.bSel = bSelT'(2'd0);
        end
        OPC_LOAD:
        begin
            d.bSel  = B_IMM;
            d.wbSel = WB_MEM;
            d.imm   = immI;
            case (f3)
                3'b000:  d.memOp = MEM_LB;
                3'b001:  d.memOp = MEM_LH;
                3'b010:  d.memOp = MEM_LW;
                3'b100:  d.memOp = MEM_LBU;
                3'b101:  d.memOp = MEM_LHU;
                default: d.illegal = 1'b1;
            endcase
        end
        OPC_STORE:
        begin
            d.regWe    = 1'b0;
            d.bSel     = B_IMM;
            d.imm      = {immI[31:5], w[11:7]};
            care.wbSel = wbSelT'(2'd0);
            case (f3)
                3'b000:  d.memOp = MEM_SB;
                3'b001:  d.memOp = MEM_SH;
                3'b010:  d.memOp = MEM_SW;
                default: d.illegal = 1'b1;
            endcase
        end
        OPC_BRANCH:
        begin
            d.regWe    = 1'b0;
            d.aluFn    = f3[2] ? (f3[1] ? ALU_SLTU : ALU_SLT) : ALU_SUB;
            d.pcSel    = PC_BRANCH;
            d.imm      = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            care.wbSel = wbSelT'(2'd0);
        end
        OPC_JAL, OPC_JALR:
        begin
            d.wbSel    = WB_PC4;
            d.pcSel    = (w[6:0] == OPC_JAL) ? PC_JAL : PC_JALR;
            d.imm      = (w[6:0] == OPC_JAL) ?
                         {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0} : immI;
            care.bSel  = bSelT'(2'd0);
            care.aluFn = aluFnT'(4'd0);
        end
        default: d.illegal = 1'b1;  // fence, system, unknown
    endcase
    if (d.illegal)
    begin
        d.regWe     = 1'b0;
        d.memOp     = MEM_NONE;
        d.pcSel     = PC_SEQ;
        care.aluFn  = aluFnT'(4'd0);
        care.bSel   = bSelT'(2'd0);
        care.wbSel  = wbSelT'(2'd0);
        care.imm    = 32'd0;
        care.target = 32'd0;
    end
    d.target = pc + d.imm;
    return d;
endfunction

`endif

/* tb/rvDecodeTb.sv */
`timescale 1ns/1ps

module rvDecodeTb;

    import rvDecodePkg::*;

    `include "decodeModel.svh"

    localparam logic [31:0] NOP = 32'h00000013;   // addi x0, x0, 0

    // stimulus plus expected bundle and its care mask
    typedef struct packed
    {
        logic [31:0] instr;
        logic [31:0] pc;
        logic        inValid;
        logic        stall;
        decodedT     exp;
        decodedT     care;
    } rowT;

    logic        clk = 1'b0;
    logic        nrst;
    logic        inValid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        stall;
    logic        outValid;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic        regWe;
    aluFnT       aluFn;
    bSelT        bSel;
    wbSelT       wbSel;
    memOpT       memOp;
    pcSelT       pcSel;
    logic [31:0] imm;
    logic [31:0] target;
    logic [31:0] pcOut;
    logic        illegal;

    decodedT     got;           // outputs packed back into a bundle
    decodedT     held;          // outputs at the previous check
    logic        heldValid;
    rowT         rows [$];
    integer      errors;
    integer      checks;
    integer      seed;
    integer      waitCnt;

    assign got = {rs1, rs2, rd, regWe, aluFn, bSel, wbSel, memOp, pcSel, imm, target, pcOut,
                  illegal};

    rvDecode rvDecode_i (.*);

    always #5 clk = ~clk;

    task automatic checkField(input string name, input logic [31:0] gotVal,
                              input logic [31:0] expVal, input logic [31:0] mask);
        checks = checks + 1;
        if (((gotVal ^ expVal) & mask) != 32'd0)
        begin
            errors = errors + 1;
            $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, gotVal, expVal);
        end
    endtask

    task automatic compareBundle(input decodedT e, input decodedT m);
        checkField("rs1", 32'(got.rs1), 32'(e.rs1), 32'(m.rs1));
        checkField("rs2", 32'(got.rs2), 32'(e.rs2), 32'(m.rs2));
        checkField("rd", 32'(got.rd), 32'(e.rd), 32'(m.rd));
        checkField("regWe", 32'(got.regWe), 32'(e.regWe), 32'(m.regWe));
        checkField("aluFn", 32'(got.aluFn), 32'(e.aluFn), 32'(m.aluFn));
        checkField("bSel", 32'(got.bSel), 32'(e.bSel), 32'(m.bSel));
        checkField("wbSel", 32'(got.wbSel), 32'(e.wbSel), 32'(m.wbSel));
        checkField("memOp", 32'(got.memOp), 32'(e.memOp), 32'(m.memOp));
        checkField("pcSel", 32'(got.pcSel), 32'(e.pcSel), 32'(m.pcSel));
        checkField("imm", got.imm, e.imm, m.imm);
        checkField("target", got.target, e.target, m.target);
        checkField("pcOut", got.pc, e.pc, m.pc);
        checkField("illegal", 32'(got.illegal), 32'(e.illegal), 32'(m.illegal));
    endtask

    task automatic checkReset();
        decodedT e;
        decodedT m;
        e       = '0;               // data outputs all zero
        e.memOp = MEM_NONE;
        e.pcSel = PC_SEQ;
        m       = '1;
        m.aluFn = aluFnT'(4'd0);
        m.bSel  = bSelT'(2'd0);
        m.wbSel = wbSelT'(2'd0);
        checkField("outValid", 32'(outValid), 32'd0, 32'd1);
        compareBundle(e, m);
    endtask

    task automatic addRow(input logic [31:0] w, input logic [31:0] p, input logic v,
                          input logic s);
        rowT     r;
        decodedT care;
        r.instr   = w;
        r.pc      = p;
        r.inValid = v;
        r.stall   = s;
        r.exp     = modelDecode(w, p, care);
        r.care    = care;
        rows.push_back(r);
    endtask

    task automatic buildTable();
        integer      i;
        logic [3:0]  k;
        logic [31:0] w;
        logic [6:0]  opcs [0:8];
        opcs = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD, OPC_STORE,
                 OPC_OPIMM, OPC_OP};
        addRow(32'h002081B3, 32'h00000100, 1'b1, 1'b0);   // add x3, x1, x2
        addRow(32'h402081B3, 32'h00000104, 1'b1, 1'b0);   // sub
        addRow(32'h007352B3, 32'h00000108, 1'b1, 1'b0);   // srl x5, x6, x7
        addRow(32'h407352B3, 32'h0000010C, 1'b1, 1'b0);   // sra
        addRow(32'hFFF00093, 32'h00000110, 1'b1, 1'b0);   // addi x1, x0, -1
        addRow(32'h4030D113, 32'h00000114, 1'b1, 1'b0);   // srai x2, x1, 3
        addRow(32'h40008093, 32'h00000118, 1'b1, 1'b0);   // addi, bit 30 keeps add
        addRow(32'h123452B7, 32'h0000011C, 1'b1, 1'b0);   // lui
        addRow(32'hFFFFF317, 32'h00000120, 1'b1, 1'b0);   // auipc, negative
        addRow(32'hFFC12383, 32'h00000124, 1'b1, 1'b0);   // lw x7, -4(x2)
        addRow(32'h0101C403, 32'h00000128, 1'b1, 1'b0);   // lbu x8, 16(x3)
        addRow(32'hFE512C23, 32'h0000012C, 1'b1, 1'b0);   // sw x5, -8(x2)
        addRow(32'h00511423, 32'h00000130, 1'b1, 1'b0);   // sh x5, 8(x2)
        addRow(32'hFE208CE3, 32'h00000004, 1'b1, 1'b0);   // beq -8, target wraps
        addRow(32'h0041C463, 32'h00000138, 1'b1, 1'b0);   // blt
        addRow(32'h0020E863, 32'h0000013C, 1'b1, 1'b0);   // bltu
        addRow(32'hFFDFF0EF, 32'h00000140, 1'b1, 1'b0);   // jal x1, -4
        addRow(32'h0010006F, 32'hFFFFF800, 1'b1, 1'b0);   // jal x0, 2048 wraps to 0
        addRow(32'h00C280E7, 32'h00000148, 1'b1, 1'b0);   // jalr x1, 12(x5)
        addRow(NOP, 32'h0000014C, 1'b0, 1'b0);            // bubble
        addRow(32'h002081B3, 32'h00000150, 1'b1, 1'b0);
        addRow(32'hFFF00093, 32'h00000154, 1'b1, 1'b1);   // dropped under stall
        addRow(32'h0FF0000F, 32'h00000158, 1'b1, 1'b1);
        addRow(32'h0FF0000F, 32'h00000158, 1'b1, 1'b0);   // fence
        addRow(32'h00000073, 32'h0000015C, 1'b1, 1'b0);   // ecall
        addRow(32'h0000007F, 32'h00000160, 1'b1, 1'b0);   // undefined opcode
        addRow(32'h00003083, 32'h00000164, 1'b1, 1'b0);   // ld, not rv32i
        addRow(32'h00003023, 32'h00000168, 1'b1, 1'b0);   // sd, not rv32i
        for (i = 0; i < 32; i = i + 1)
        begin
            w = $random(seed);
            if (i % 2 == 1)
            begin
                k       = 4'($unsigned($random(seed)) % 9);
                w[6:0]  = opcs[k];  // force a supported class
            end
            addRow(w, $random(seed), ($random(seed) & 7) != 0, ($random(seed) & 3) == 0);
        end
    endtask

    task automatic checkRow(input rowT r);
        if (r.stall)
        begin
            checkField("outValid", 32'(outValid), 32'(heldValid), 32'd1);
            compareBundle(held, '1);
        end
        else if (r.inValid)
        begin
            checkField("outValid", 32'(outValid), 32'd1, 32'd1);
            compareBundle(r.exp, r.care);
        end
        else
            checkField("outValid", 32'(outValid), 32'd0, 32'd1);
    endtask

    // drive row i, then check the row the last edge took in
    task automatic runTable();
        integer i;
        for (i = 0; i <= rows.size(); i = i + 1)
        begin
            @(posedge clk);
            if (i < rows.size())
            begin
                instr   <= rows[i].instr;
                pc      <= rows[i].pc;
                inValid <= rows[i].inValid;
                stall   <= rows[i].stall;
            end
            else
            begin
                inValid <= 1'b0;
                stall   <= 1'b0;
            end
            @(negedge clk);
            if (i > 0)
                checkRow(rows[i - 1]);
            held      = got;
            heldValid = outValid;
        end
    endtask

    initial
    begin
        nrst = 1'b0;
        repeat (8) @(posedge clk);
        nrst <= 1'b1;
    end

    initial
    begin
        errors  = 0;
        checks  = 0;
        seed    = 11510;
        inValid = 1'b0;
        stall   = 1'b0;
        instr   = NOP;
        pc      = 32'd0;
        buildTable();
        repeat (3) @(negedge clk);
        checkReset();
        waitCnt = 0;
        while (!nrst && waitCnt < 20)
        begin
            @(negedge clk);
            waitCnt = waitCnt + 1;
        end
        if (!nrst)
        begin
            $display("timeout: reset was never released");
            $display("Errors found");
            $finish;
        end
        else
        begin
            checkReset();   // no edge has seen nrst high yet
            runTable();
            $display("checks %0d, errors %0d", checks, errors);
            if (errors == 0)
                $display("No errors");
            else
                $display("Errors found");
            $finish;
        end
    end

endmodule

/* rvDecode.f */
+incdir+tb
design/rvDecodePkg.sv
design/immIf.sv
design/ctrlIf.sv
design/immGen.sv
design/controlDecoder.sv
design/decodeMerge.sv
design/rvDecode.sv
tb/rvDecodeTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --timing
TOP      = rvDecodeTb
FILELIST = rvDecode.f
OBJDIR   = obj_dir
LOG      = sim.log
PASSMSG  = No errors

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary -j 0 $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASSMSG)$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
